/* filelist.f */
rtl/rv_core_pkg.sv
rtl/instruction_decoder.sv
rtl/control_unit.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/rv_core_top.sv
verification/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if grep -qx "Finished with no errors" <<< "$out"; then
    exit 0
else
    exit 1
fi

/* verification/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               imem_req;
    rv_core_pkg::word_t imem_addr;
    logic               imem_ack;
    rv_core_pkg::word_t imem_rdata;
    logic               dmem_req;
    logic               dmem_we;
    rv_core_pkg::word_t dmem_addr;
    rv_core_pkg::word_t dmem_wdata;
    logic               dmem_ack;
    rv_core_pkg::word_t dmem_rdata;
    logic               halted;

    rv_core_pkg::word_t imem [0:63];                // Program image
    rv_core_pkg::word_t dmem [0:63];                // Data memory seen by the DUT
    rv_core_pkg::word_t ref_mem [0:63];             // Model copy of data memory
    rv_core_pkg::word_t ref_regs [0:31];
    rv_core_pkg::word_t exp_pc;
    rv_core_pkg::word_t st_addr;
    rv_core_pkg::word_t st_data;
    rv_core_pkg::word_t ia_hold;                    // Address at request rise
    rv_core_pkg::word_t da_hold;
    logic               st_valid;
    logic               st_pending;                 // Model store not yet seen on the bus
    logic               m_halt = 1'b0;
    logic               prev_ireq = 1'b0;
    logic               prev_dreq = 1'b0;
    int                 n_words = 0;
    int                 i_wait;
    int                 d_wait;
    int                 err_value = 0;
    int                 err_other = 0;

    rv_core_top UUT (
        .clk, .arst_n, .imem_req, .imem_addr, .imem_ack, .imem_rdata, .dmem_req, .dmem_we,
        .dmem_addr, .dmem_wdata, .dmem_ack, .dmem_rdata, .halted
    );

    always #5 clk = ~clk;                           // 10 ns period

    function automatic rv_core_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rs2,
                                                 logic [4:0] rs1, logic [2:0] f3,
                                                 logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic rv_core_pkg::word_t enc_i(logic [31:0] imm, logic [4:0] rs1,
                                                 logic [2:0] f3, logic [4:0] rd,
                                                 logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rv_core_pkg::word_t enc_s(logic [31:0] imm, logic [4:0] rs2,
                                                 logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};       // sw only
    endfunction

    function automatic rv_core_pkg::word_t enc_b(logic [31:0] imm, logic [4:0] rs2,
                                                 logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic rv_core_pkg::word_t enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(rv_core_pkg::word_t w);
        imem[n_words] = w;
        n_words++;
    endtask

    task automatic op_and_store(rv_core_pkg::word_t ins, int off);
        emit(ins);                                  // Result lands in x3
        emit(enc_s(off, 3, 10));                    // sw x3, off(x10)
    endtask

    // Reference model stepping one instruction and returning the next pc
    function automatic rv_core_pkg::word_t model_step(rv_core_pkg::word_t pc,
                                                      rv_core_pkg::word_t ins);
        rv_core_pkg::word_t a, b, ii, si, bi, ji, res, nxt;
        logic               wr;
        a   = ref_regs[ins[19:15]];
        ii  = {{20{ins[31]}}, ins[31:20]};
        si  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bi  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        ji  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        b   = ins[5] ? ref_regs[ins[24:20]] : ii;   // Bit 5 splits reg from imm ALU ops
        nxt = pc + 4;
        wr  = 1'b1;
        res = '0;
        st_valid = 1'b0;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'h000};                       // lui
            7'h6f: begin
                res = pc + 4;
                nxt = pc + ji;
            end
            7'h67: begin
                res = pc + 4;
                nxt = (a + ii) & ~32'h1;
            end
            7'h63: begin
                wr = 1'b0;
                if ((a == ref_regs[ins[24:20]]) ^ ins[12]) nxt = pc + bi;
            end
            7'h03: res = ref_mem[(a + ii) >> 2 & 63];
            7'h23: begin
                wr       = 1'b0;
                st_valid = 1'b1;
                st_addr  = a + si;
                st_data  = ref_regs[ins[24:20]];
                ref_mem[st_addr >> 2 & 63] = st_data;
            end
            7'h13, 7'h33: begin
                case (ins[14:12])
                    3'd0:    res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'd1:    res = a << b[4:0];
                    3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd4:    res = a ^ b;
                    3'd5:    res = a >> b[4:0];
                    3'd6:    res = a | b;
                    default: res = a & b;
                endcase
            end
            default: begin                          // Illegal
                wr     = 1'b0;
                m_halt = 1'b1;
                nxt    = pc;
            end
        endcase
        if (wr && ins[11:7] != 0) ref_regs[ins[11:7]] = res;
        return nxt;
    endfunction

    task automatic check_word(string name, rv_core_pkg::word_t got, rv_core_pkg::word_t exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_store(rv_core_pkg::word_t ga, rv_core_pkg::word_t gd,
                               rv_core_pkg::word_t ea, rv_core_pkg::word_t ed);
        check_word("dmem_addr", ga, ea);
        check_word("dmem_wdata", gd, ed);
    endtask

    task automatic check_halt(logic got, logic exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR halted got %h expected %h", got, exp);
        end
    endtask

    // Instruction memory responder with a random delay before ack
    always @(negedge clk) begin
        if (imem_req && !imem_ack) begin
            if (i_wait != 0) i_wait = i_wait - 1;
            else begin
                imem_ack   = 1'b1;
                imem_rdata = imem[imem_addr[7:2]];
            end
        end else if (!imem_req && imem_ack) begin
            imem_ack = 1'b0;
            i_wait   = $urandom_range(7, 0);
        end
    end

    // Data memory responder
    always @(negedge clk) begin
        if (dmem_req && !dmem_ack) begin
            if (d_wait != 0) d_wait = d_wait - 1;
            else begin
                dmem_ack = 1'b1;
                if (dmem_we) dmem[dmem_addr[7:2]] = dmem_wdata;
                else dmem_rdata = dmem[dmem_addr[7:2]];
            end
        end else if (!dmem_req && dmem_ack) begin
            dmem_ack = 1'b0;
            d_wait   = $urandom_range(7, 0);
        end
    end

    // Model compare at each request rise and address hold checks while waiting
    always @(negedge clk) begin
        if (arst_n) begin
            if (imem_req && !prev_ireq) begin
                ia_hold = imem_addr;
                if (m_halt) begin
                    err_other++;
                    $display("Fetch request issued after the core should have halted");
                end else begin
                    if (st_pending) begin
                        err_other++;
                        $display("Expected store to %h was never issued", st_addr);
                    end
                    check_word("imem_addr", imem_addr, exp_pc);
                    exp_pc     = model_step(exp_pc, imem[exp_pc[7:2]]);
                    st_pending = st_valid;
                end
            end else if (imem_req) check_word("imem_addr", imem_addr, ia_hold);
            if (dmem_req && !prev_dreq) begin
                da_hold = dmem_addr;
                if (dmem_we && !st_pending) begin
                    err_other++;
                    $display("Store issued where the model has none");
                end else if (dmem_we) begin
                    check_store(dmem_addr, dmem_wdata, st_addr, st_data);
                    st_pending = 1'b0;
                end
            end else if (dmem_req) check_word("dmem_addr", dmem_addr, da_hold);
            prev_ireq = imem_req;
            prev_dreq = dmem_req;
        end
    end

    initial begin
        i_wait     = $urandom(32'ha3912151) % 8;    // Seeds the run
        arst_n     = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        d_wait     = $urandom_range(7, 0);
        exp_pc     = rv_core_pkg::reset_pc;
        st_pending = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i]    = 32'hdead_0000 + i;         // Filler for words never fetched
            dmem[i]    = 32'h5a00_0000 ^ (i * 32'h9e37_79b9);
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        emit({20'h00001, 5'd10, 7'h37});            // x10 = data base 0x1000
        emit(enc_i(-5, 0, 0, 1, 7'h13));            // x1 = -5
        emit(enc_i(3, 0, 0, 2, 7'h13));             // x2 = 3
        op_and_store(enc_r(7'h00, 2, 1, 3'd0, 3), 0);
        op_and_store(enc_r(7'h20, 2, 1, 3'd0, 3), 4);
        op_and_store(enc_r(7'h00, 2, 1, 3'd2, 3), 8);
        op_and_store(enc_r(7'h00, 2, 1, 3'd1, 3), 12);
        op_and_store(enc_r(7'h00, 2, 1, 3'd5, 3), 16);
        op_and_store(enc_r(7'h00, 2, 1, 3'd4, 3), 20);
        op_and_store(enc_r(7'h00, 2, 1, 3'd6, 3), 24);
        op_and_store(enc_r(7'h00, 2, 1, 3'd7, 3), 28);
        op_and_store(enc_i(32'h0f0, 1, 3'd7, 3, 7'h13), 32);
        op_and_store(enc_i(-256, 1, 3'd6, 3, 7'h13), 36);
        op_and_store(enc_i(-1, 2, 3'd4, 3, 7'h13), 40);
        op_and_store(enc_i(-4, 1, 3'd2, 3, 7'h13), 44);
        op_and_store(enc_i(-100, 1, 3'd0, 3, 7'h13), 48);
        emit(enc_j(8, 5));                          // jal x5 over one word
        emit(enc_i(99, 0, 0, 3, 7'h13));            // Skipped
        emit(enc_s(80, 5, 10));
        emit(enc_i((n_words + 3) * 4, 0, 0, 6, 7'h13));
        emit(enc_i(1, 6, 0, 7, 7'h67));             // jalr x7, 1(x6) with bit 0 dropped
        emit(enc_i(77, 0, 0, 3, 7'h13));            // Skipped
        emit(enc_s(84, 7, 10));
        emit(enc_b(8, 1, 1, 3'd0));                 // beq taken
        emit(enc_i(55, 0, 0, 3, 7'h13));
        emit(enc_b(8, 2, 1, 3'd0));                 // beq not taken
        emit(enc_b(8, 2, 1, 3'd1));                 // bne taken
        emit(enc_i(66, 0, 0, 3, 7'h13));
        emit(enc_b(8, 1, 1, 3'd1));                 // bne not taken
        emit(enc_i(0, 10, 3'd2, 8, 7'h03));         // lw x8, 0(x10)
        emit(enc_i(1, 8, 0, 8, 7'h13));
        emit(enc_s(88, 8, 10));
        emit(enc_i(88, 10, 3'd2, 9, 7'h03));        // Read back own store
        emit(enc_s(92, 9, 10));
        emit(enc_i(160, 10, 3'd2, 11, 7'h03));      // Untouched memory word
        emit(enc_s(96, 11, 10));
        emit(32'h0000_0000);                        // Illegal opcode
        repeat (10) @(negedge clk);
        if (imem_req || dmem_req || halted) begin
            err_other++;
            $display("Request or halt active during reset");
        end
        arst_n = 1'b1;
        wait (m_halt);
        for (int k = 0; k < 40 && !halted; k++) @(negedge clk);
        check_halt(halted, 1'b1);
        repeat (20) @(negedge clk);                 // Any late fetch is caught above
        check_halt(halted, 1'b1);
        $display("Value errors %0d, other errors %0d", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per program word plus reset
    initial begin
        #1;
        repeat (n_words * 40 + 10) @(posedge clk);
        $display("Timeout, core hung with pc %h expected", exp_pc);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
`default_nettype none

module rv_core_top (
    input  logic               clk,
    input  logic               arst_n,
    output logic               imem_req,
    output rv_core_pkg::word_t imem_addr,
    input  logic               imem_ack,
    input  rv_core_pkg::word_t imem_rdata,
    output logic               dmem_req,
    output logic               dmem_we,
    output rv_core_pkg::word_t dmem_addr,
    output rv_core_pkg::word_t dmem_wdata,
    input  logic               dmem_ack,
    input  rv_core_pkg::word_t dmem_rdata,
    output logic               halted
);

    rv_core_pkg::word_t                 pc;
    rv_core_pkg::word_t                 instr;
    rv_core_pkg::word_t                 imm;
    rv_core_pkg::word_t                 target;         // Jump target and data address
    rv_core_pkg::word_t                 alu_result;
    rv_core_pkg::word_t                 wb_data;
    rv_core_pkg::word_t                 rs1_data;
    rv_core_pkg::word_t                 rs2_data;
    rv_core_pkg::opcode_e               opcode;
    rv_core_pkg::instr_type_e           instr_type;
    rv_core_pkg::op_a_sel_e             op_a_sel;
    rv_core_pkg::op_b_sel_e             op_b_sel;
    rv_core_pkg::alu_op_e               alu_op;
    logic [2:0]                         funct3;
    logic [6:0]                         funct7;
    logic [rv_core_pkg::reg_addr_w-1:0] rs1;
    logic [rv_core_pkg::reg_addr_w-1:0] rs2;
    logic [rv_core_pkg::reg_addr_w-1:0] rd;
    logic                               fetch_enable;
    logic                               ir_enable;
    logic                               pc_enable;
    logic                               pc_select;
    logic                               address_type;
    logic                               lsu_enable;
    logic                               lsu_write;
    logic                               read_enable_1;
    logic                               read_enable_2;
    logic                               write_enable;
    logic                               wb_select;
    logic                               fetch_done;
    logic                               lsu_done;
    logic                               branch_taken;

    fetch_unit u_fetch (
        .clk, .arst_n, .fetch_enable, .ir_enable, .pc_enable, .pc_select, .target,
        .imem_ack, .imem_rdata, .imem_req, .imem_addr, .pc, .instr, .fetch_done
    );

    instruction_decoder u_decoder (
        .instr, .opcode, .funct3, .funct7, .rs1, .rs2, .rd, .imm, .instr_type
    );

    control_unit u_control (
        .clk, .arst_n, .opcode, .funct3, .funct7, .instr_type, .fetch_done, .lsu_done,
        .branch_taken, .fetch_enable, .ir_enable, .pc_enable, .pc_select, .address_type,
        .op_a_sel, .op_b_sel, .alu_op, .lsu_enable, .lsu_write, .read_enable_1,
        .read_enable_2, .write_enable, .wb_select, .halted
    );

    register_file u_regs (
        .clk, .arst_n, .read_enable_1, .read_enable_2, .write_enable, .rs1, .rs2, .rd,
        .rd_data (wb_data), .rs1_data, .rs2_data
    );

    execute_unit u_execute (
        .op_a_sel, .op_b_sel, .alu_op, .address_type, .funct3, .rs1_data, .rs2_data,
        .pc, .imm, .alu_result, .target, .branch_taken
    );

    load_store_unit u_lsu (
        .clk, .arst_n, .lsu_enable, .lsu_write, .wb_select,
        .address (target), .store_data (rs2_data), .alu_result,
        .dmem_ack, .dmem_rdata, .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata,
        .lsu_done, .wb_data
    );

endmodule

`default_nettype wire

/* rtl/load_store_unit.sv */
`default_nettype none

module load_store_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               lsu_enable,
    input  logic               lsu_write,
    input  logic               wb_select,
    input  rv_core_pkg::word_t address,
    input  rv_core_pkg::word_t store_data,
    input  rv_core_pkg::word_t alu_result,
    input  logic               dmem_ack,
    input  rv_core_pkg::word_t dmem_rdata,
    output logic               dmem_req,
    output logic               dmem_we,
    output rv_core_pkg::word_t dmem_addr,
    output rv_core_pkg::word_t dmem_wdata,
    output logic               lsu_done,
    output rv_core_pkg::word_t wb_data
);

    typedef enum logic [1:0] {
        m_idle,
        m_req,
        m_drop
    } mem_state_e;

    mem_state_e         mstate;
    rv_core_pkg::word_t load_data;              // Captured read data

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstate  <= m_idle;
            dmem_we <= 1'b0;
        end else begin
            case (mstate)
                m_idle: if (lsu_enable) begin
                    mstate  <= m_req;
                    dmem_we <= lsu_write;
                end
                m_req:   if (dmem_ack) mstate <= m_drop;
                m_drop:  if (!dmem_ack) mstate <= m_idle;
                default: mstate <= m_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mstate == m_idle && lsu_enable) begin
            dmem_addr  <= address;              // Stable until ack
            dmem_wdata <= store_data;
        end
        if (mstate == m_req && dmem_ack && !dmem_we) begin
            load_data <= dmem_rdata;
        end
    end

    assign dmem_req = mstate == m_req;
    assign lsu_done = (mstate == m_drop) && !dmem_ack;
    assign wb_data  = wb_select ? load_data : alu_result;

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`default_nettype none

module execute_unit (
    input  rv_core_pkg::op_a_sel_e op_a_sel,
    input  rv_core_pkg::op_b_sel_e op_b_sel,
    input  rv_core_pkg::alu_op_e   alu_op,
    input  logic                   address_type,
    input  logic [2:0]             funct3,
    input  rv_core_pkg::word_t     rs1_data,
    input  rv_core_pkg::word_t     rs2_data,
    input  rv_core_pkg::word_t     pc,
    input  rv_core_pkg::word_t     imm,
    output rv_core_pkg::word_t     alu_result,
    output rv_core_pkg::word_t     target,
    output logic                   branch_taken
);

    rv_core_pkg::word_t op_a;
    rv_core_pkg::word_t op_b;

    always_comb begin
        case (op_a_sel)
            rv_core_pkg::a_rs1: op_a = rs1_data;
            rv_core_pkg::a_pc:  op_a = pc;
            default:            op_a = '0;
        endcase
        case (op_b_sel)
            rv_core_pkg::b_rs2: op_b = rs2_data;
            rv_core_pkg::b_imm: op_b = imm;
            default:            op_b = 32'd4;
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_core_pkg::alu_sub:    alu_result = op_a - op_b;
            rv_core_pkg::alu_and:    alu_result = op_a & op_b;
            rv_core_pkg::alu_or:     alu_result = op_a | op_b;
            rv_core_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_core_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::alu_sll:    alu_result = op_a << op_b[4:0];  // Shamt in low 5 bits
            rv_core_pkg::alu_srl:    alu_result = op_a >> op_b[4:0];
            rv_core_pkg::alu_pass_b: alu_result = op_b;
            default:                 alu_result = op_a + op_b;
        endcase
    end

    // Address generator, shared by jump targets and data addresses
    assign target = address_type ? rs1_data + imm : pc + imm;

    assign branch_taken = funct3[0] ? (rs1_data != rs2_data) : (rs1_data == rs2_data);  // bne/beq

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`default_nettype none

module register_file (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               read_enable_1,
    input  logic                               read_enable_2,
    input  logic                               write_enable,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rd,
    input  rv_core_pkg::word_t                 rd_data,
    output rv_core_pkg::word_t                 rs1_data,
    output rv_core_pkg::word_t                 rs2_data
);

    rv_core_pkg::word_t regs [1:31];            // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (write_enable && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (read_enable_1 && rs1 != '0) ? regs[rs1] : '0;
    assign rs2_data = (read_enable_2 && rs2 != '0) ? regs[rs2] : '0;

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fetch_enable,
    input  logic               ir_enable,
    input  logic               pc_enable,
    input  logic               pc_select,
    input  rv_core_pkg::word_t target,
    input  logic               imem_ack,
    input  rv_core_pkg::word_t imem_rdata,
    output logic               imem_req,
    output rv_core_pkg::word_t imem_addr,
    output rv_core_pkg::word_t pc,
    output rv_core_pkg::word_t instr,
    output logic               fetch_done
);

    typedef enum logic [1:0] {
        f_idle,
        f_req,                                  // Request up, waiting for ack
        f_drop                                  // Request down, waiting for ack low
    } fetch_state_e;

    fetch_state_e fstate;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fstate <= f_idle;
            pc     <= rv_core_pkg::reset_pc;
        end else begin
            case (fstate)
                f_idle:  if (fetch_enable || ir_enable) fstate <= f_req;
                f_req:   if (imem_ack) fstate <= f_drop;
                f_drop:  if (!imem_ack) fstate <= f_idle;
                default: fstate <= f_idle;
            endcase
            if (pc_enable) begin
                pc <= pc_select ? {target[31:1], 1'b0} : pc + 32'd4;  // Bit 0 cleared for jalr
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fstate == f_req && imem_ack) begin
            instr <= imem_rdata;                // IR load on ack
        end
    end

    assign imem_req   = fstate == f_req;
    assign imem_addr  = pc;                     // Held, pc only moves in writeback
    assign fetch_done = (fstate == f_drop) && !imem_ack;

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
`default_nettype none

module control_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  rv_core_pkg::opcode_e     opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    input  rv_core_pkg::instr_type_e instr_type,
    input  logic                     fetch_done,
    input  logic                     lsu_done,
    input  logic                     branch_taken,
    output logic                     fetch_enable,
    output logic                     ir_enable,
    output logic                     pc_enable,
    output logic                     pc_select,
    output logic                     address_type,
    output rv_core_pkg::op_a_sel_e   op_a_sel,
    output rv_core_pkg::op_b_sel_e   op_b_sel,
    output rv_core_pkg::alu_op_e     alu_op,
    output logic                     lsu_enable,
    output logic                     lsu_write,
    output logic                     read_enable_1,
    output logic                     read_enable_2,
    output logic                     write_enable,
    output logic                     wb_select,
    output logic                     halted
);

    rv_core_pkg::core_state_e state;
    rv_core_pkg::core_state_e state_next;
    logic                     is_mem;           // Load or store
    logic                     rd_phase;         // Register reads allowed
    logic                     re1;              // Unqualified read/write enables
    logic                     re2;
    logic                     we;

    assign is_mem = (opcode == rv_core_pkg::op_load) || (opcode == rv_core_pkg::op_store);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rv_core_pkg::st_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            rv_core_pkg::st_fetch:     if (fetch_done) state_next = rv_core_pkg::st_decode;
            rv_core_pkg::st_decode:    state_next = (instr_type == rv_core_pkg::bad_type) ?
                                                    rv_core_pkg::st_halt : rv_core_pkg::st_execute;
            rv_core_pkg::st_execute:   state_next = is_mem ? rv_core_pkg::st_memory :
                                                             rv_core_pkg::st_writeback;
            rv_core_pkg::st_memory:    if (lsu_done) state_next = rv_core_pkg::st_writeback;
            rv_core_pkg::st_writeback: state_next = rv_core_pkg::st_fetch;
            default:                   state_next = rv_core_pkg::st_halt;  // Stuck until reset
        endcase
    end

    // Register file ports used per instruction type
    always_comb begin
        re1 = 1'b0;
        re2 = 1'b0;
        we  = 1'b0;
        case (instr_type)
            rv_core_pkg::i_type: begin
                re1 = 1'b1;
                we  = 1'b1;                     // ALU imm, load, jalr link
            end
            rv_core_pkg::b_type,
            rv_core_pkg::s_type: begin
                re1 = 1'b1;
                re2 = 1'b1;
            end
            rv_core_pkg::u_type,
            rv_core_pkg::j_type: we = 1'b1;
            rv_core_pkg::r_type: begin
                re1 = 1'b1;
                re2 = 1'b1;
                we  = 1'b1;
            end
            default: ;                          // Illegal, nothing enabled
        endcase
    end

    // Operand selects and ALU function
    always_comb begin
        op_a_sel = rv_core_pkg::a_zero;
        op_b_sel = rv_core_pkg::b_imm;
        alu_op   = rv_core_pkg::alu_add;
        case (opcode)
            rv_core_pkg::op_imm,
            rv_core_pkg::op_reg: begin
                op_a_sel = rv_core_pkg::a_rs1;
                op_b_sel = (opcode == rv_core_pkg::op_reg) ? rv_core_pkg::b_rs2 :
                                                             rv_core_pkg::b_imm;
                case (funct3)
                    3'd1:    alu_op = rv_core_pkg::alu_sll;
                    3'd2:    alu_op = rv_core_pkg::alu_slt;
                    3'd4:    alu_op = rv_core_pkg::alu_xor;
                    3'd5:    alu_op = rv_core_pkg::alu_srl;
                    3'd6:    alu_op = rv_core_pkg::alu_or;
                    3'd7:    alu_op = rv_core_pkg::alu_and;
                    default: alu_op = (opcode == rv_core_pkg::op_reg && funct7[5]) ?
                                      rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
                endcase
            end
            rv_core_pkg::op_jal,
            rv_core_pkg::op_jalr: begin
                op_a_sel = rv_core_pkg::a_pc;   // Link = pc + 4
                op_b_sel = rv_core_pkg::b_four;
            end
            rv_core_pkg::op_lui: alu_op = rv_core_pkg::alu_pass_b;
            default: ;
        endcase
    end

    assign rd_phase      = (state != rv_core_pkg::st_fetch) && (state != rv_core_pkg::st_halt);
    assign read_enable_1 = re1 && rd_phase;
    assign read_enable_2 = re2 && rd_phase;
    assign write_enable  = we && (state == rv_core_pkg::st_writeback);

    assign fetch_enable  = state == rv_core_pkg::st_fetch;
    assign ir_enable     = state == rv_core_pkg::st_writeback;  // Launch next fetch
    assign pc_enable     = state == rv_core_pkg::st_writeback;
    assign pc_select     = (opcode == rv_core_pkg::op_jal) || (opcode == rv_core_pkg::op_jalr) ||
                           ((opcode == rv_core_pkg::op_branch) && branch_taken);
    assign address_type  = is_mem || (opcode == rv_core_pkg::op_jalr);  // 1: rs1 + imm
    assign lsu_enable    = is_mem && (state == rv_core_pkg::st_memory);
    assign lsu_write     = opcode == rv_core_pkg::op_store;
    assign wb_select     = opcode == rv_core_pkg::op_load;    // Load data over ALU
    assign halted        = state == rv_core_pkg::st_halt;

endmodule

`default_nettype wire

/* rtl/instruction_decoder.sv */
`default_nettype none

module instruction_decoder (
    input  rv_core_pkg::word_t                 instr,
    output rv_core_pkg::opcode_e               opcode,
    output logic [2:0]                         funct3,
    output logic [6:0]                         funct7,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd,
    output rv_core_pkg::word_t                 imm,
    output rv_core_pkg::instr_type_e           instr_type
);

    assign opcode = rv_core_pkg::opcode_e'(instr[6:0]);    // Raw bits, may be off-enum
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        case (opcode)
            rv_core_pkg::op_imm,
            rv_core_pkg::op_load,
            rv_core_pkg::op_jalr:   instr_type = rv_core_pkg::i_type;
            rv_core_pkg::op_branch: instr_type = rv_core_pkg::b_type;
            rv_core_pkg::op_store:  instr_type = rv_core_pkg::s_type;
            rv_core_pkg::op_lui:    instr_type = rv_core_pkg::u_type;
            rv_core_pkg::op_jal:    instr_type = rv_core_pkg::j_type;
            rv_core_pkg::op_reg:    instr_type = rv_core_pkg::r_type;
            default:                instr_type = rv_core_pkg::bad_type;
        endcase
    end

    // Immediate layout picked by instruction type, sign from bit 31
    always_comb begin
        case (instr_type)
            rv_core_pkg::i_type: imm = {{20{instr[31]}}, instr[31:20]};
            rv_core_pkg::s_type: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_core_pkg::b_type: imm = {{19{instr[31]}}, instr[31], instr[7],
                                        instr[30:25], instr[11:8], 1'b0};
            rv_core_pkg::u_type: imm = {instr[31:12], 12'h000};
            rv_core_pkg::j_type: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                        instr[20], instr[30:21], 1'b0};
            default:             imm = '0;      // R-type and illegal
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;                    // Data, address and instruction word

    localparam word_t reset_pc   = 32'h0000_0000;   // First fetch address
    localparam int    reg_addr_w = 5;               // Register index width

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        i_type   = 3'd0,
        b_type   = 3'd1,
        s_type   = 3'd2,
        u_type   = 3'd3,
        j_type   = 3'd4,
        r_type   = 3'd6,
        bad_type = 3'd7                             // Unknown opcode, halts core
    } instr_type_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b                                  // LUI result
    } alu_op_e;

    typedef enum logic [1:0] {
        a_rs1,
        a_pc,
        a_zero
    } op_a_sel_e;

    typedef enum logic [1:0] {
        b_rs2,
        b_imm,
        b_four                                      // Link value pc+4
    } op_b_sel_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halt
    } core_state_e;

endpackage

`default_nettype wire
